// File: verilog.f
hdl/bus_pkg.sv
hdl/gpio_pkg.sv
hdl/dbus_decode.sv
hdl/gpio_bank.sv
hdl/dbus_return.sv
hdl/gpio_subsys_top.sv
tb/gpio_subsys_tb.sv

// File: Makefile
TOP = gpio_subsys_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: tb/gpio_subsys_tb.sv
`timescale 1ns/1ps

module gpio_subsys_tb
    import bus_pkg::*;
    import gpio_pkg::*;
();

    localparam int NUM_BANKS = 4;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_PINS,
        OP_IDLE
    } op_e;

    // for PINS rows addr carries the bank index and data the pin pattern
    typedef struct packed {
        op_e                  op;
        addr_t                addr;
        data_t                data;
        byte_en_t             be;
        data_t                exp_data;
        data_t                exp_oe;
        logic [NUM_BANKS-1:0] exp_irq;
    } row_t;

    logic                 clk;
    logic                 reset_i;
    bus_req_t             dbus_req;
    data_t                dbus_rddata;
    logic                 dbus_stall;
    pin_t                 gpio_pins_i [NUM_BANKS];
    pin_t                 gpio_pins_o [NUM_BANKS];
    pin_t                 gpio_oe_o [NUM_BANKS];
    logic [NUM_BANKS-1:0] irq;

    row_t   rows[$];
    pin_t   m_out [NUM_BANKS];
    pin_t   m_dir [NUM_BANKS];
    pin_t   m_in [NUM_BANKS];
    pin_t   m_edge [NUM_BANKS];
    int     errors;
    int     checks;
    int     cycles;
    int     cycle_limit;
    integer seed;

    gpio_subsys_top #(
        .NUM_BANKS(NUM_BANKS)
    ) uut (
        .clk          (clk),
        .reset_i      (reset_i),
        .dbus_req_i   (dbus_req),
        .dbus_rddata_o(dbus_rddata),
        .dbus_stall_o (dbus_stall),
        .gpio_pins_i  (gpio_pins_i),
        .gpio_pins_o  (gpio_pins_o),
        .gpio_oe_o    (gpio_oe_o),
        .irq_o        (irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic addr_t reg_addr(int bank, gpio_reg_e r);
        reg_addr = {GPIO_BASE, 8'(bank), r, 2'b00};
    endfunction

    function automatic logic is_mapped(addr_t a);
        is_mapped = (a[31:12] == GPIO_BASE) && (int'(a[11:4]) < NUM_BANKS);
    endfunction

    // unmapped bank indices fold back onto a real bank for the pin check
    function automatic int pin_bank(addr_t a);
        pin_bank = int'(a[11:4]) % NUM_BANKS;
    endfunction

    function automatic data_t byte_mask(byte_en_t be);
        data_t m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{be[i]}};
        end
        byte_mask = m;
    endfunction

    function automatic logic [NUM_BANKS-1:0] model_irq();
        logic [NUM_BANKS-1:0] v;
        for (int b = 0; b < NUM_BANKS; b++) begin
            v[b] = |m_edge[b];
        end
        model_irq = v;
    endfunction

    task automatic add_write(addr_t a, data_t d, byte_en_t be);
        row_t  r;
        data_t m;
        int    b;
        m = byte_mask(be);
        b = int'(a[11:4]);
        if (is_mapped(a)) begin
            case (gpio_reg_e'(a[3:2]))
                REG_OUT:  m_out[b] = (m_out[b] & ~m) | (d & m);
                REG_DIR:  m_dir[b] = (m_dir[b] & ~m) | (d & m);
                REG_EDGE: m_edge[b] = m_edge[b] & ~(d & m);
                default:  m_in[b] = m_in[b];
            endcase
        end
        b = pin_bank(a);
        r = '{op: OP_WRITE, addr: a, data: d, be: be, exp_data: m_out[b],
              exp_oe: m_dir[b], exp_irq: model_irq()};
        rows.push_back(r);
    endtask

    task automatic add_read(addr_t a);
        row_t  r;
        data_t exp;
        int    b;
        exp = '0;
        b = int'(a[11:4]);
        if (is_mapped(a)) begin
            case (gpio_reg_e'(a[3:2]))
                REG_OUT: exp = m_out[b];
                REG_DIR: exp = m_dir[b];
                REG_IN:  exp = m_in[b];
                default: exp = m_edge[b];
            endcase
        end
        r = '{op: OP_READ, addr: a, data: '0, be: '0, exp_data: exp,
              exp_oe: '0, exp_irq: model_irq()};
        rows.push_back(r);
    endtask

    // rising inputs on pins with DIR clear are captured once the value settles
    task automatic add_pins(int bank, pin_t v);
        row_t r;
        m_edge[bank] = m_edge[bank] | (v & ~m_in[bank] & ~m_dir[bank]);
        m_in[bank] = v;
        r = '{op: OP_PINS, addr: addr_t'(bank), data: v, be: '0, exp_data: '0,
              exp_oe: '0, exp_irq: model_irq()};
        rows.push_back(r);
    endtask

    task automatic add_idle();
        row_t r;
        r = '{op: OP_IDLE, addr: '0, data: '0, be: '0, exp_data: '0,
              exp_oe: '0, exp_irq: model_irq()};
        rows.push_back(r);
    endtask

    task automatic build_table();
        pin_t v;
        for (int b = 0; b < NUM_BANKS; b++) begin
            m_out[b] = '0;
            m_dir[b] = '0;
            m_in[b] = '0;
            m_edge[b] = '0;
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < 4; r++) begin
                add_read(reg_addr(b, gpio_reg_e'(r)));
            end
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            add_write(reg_addr(b, REG_OUT), 32'h5a5a_0000 + 32'h0111 * b, 4'hf);
            add_write(reg_addr(b, REG_DIR), 32'h0000_ffff ^ (32'h100 << b), 4'hf);
            add_read(reg_addr(b, REG_OUT));
            add_read(reg_addr(b, REG_DIR));
        end
        add_idle();
        add_write(reg_addr(1, REG_OUT), 32'hffff_ffff, 4'b0101);
        add_read(reg_addr(1, REG_OUT));
        add_write(reg_addr(2, REG_DIR), 32'h1234_5678, 4'b1000);
        add_read(reg_addr(2, REG_DIR));
        add_write(reg_addr(3, REG_OUT), 32'h0000_00c3, 4'b0000);
        add_read(reg_addr(3, REG_OUT));
        for (int b = 0; b < NUM_BANKS; b++) begin
            v = pin_t'($random(seed));
            add_pins(b, v);
            add_read(reg_addr(b, REG_IN));
            add_write(reg_addr(b, REG_IN), ~v, 4'hf);
            add_read(reg_addr(b, REG_IN));
            add_read(reg_addr(b, REG_EDGE));
        end
        // clear everything the random patterns captured
        for (int b = 0; b < NUM_BANKS; b++) begin
            add_write(reg_addr(b, REG_EDGE), 32'hffff_ffff, 4'hf);
            add_read(reg_addr(b, REG_EDGE));
        end
        // bit 3 of bank 0 is an output, bit 16 an input
        add_pins(0, 32'h0000_0000);
        add_pins(0, 32'h0001_0008);
        add_read(reg_addr(0, REG_EDGE));
        add_write(reg_addr(0, REG_EDGE), 32'h0001_0000, 4'b0100);
        add_read(reg_addr(0, REG_EDGE));
        add_pins(3, 32'h0000_0000);
        add_pins(3, 32'h8001_0000);
        add_read(reg_addr(3, REG_EDGE));
        add_write(reg_addr(3, REG_EDGE), 32'hffff_ffff, 4'b1000);
        add_read(reg_addr(3, REG_EDGE));
        add_write(reg_addr(3, REG_EDGE), 32'hffff_ffff, 4'b0100);
        add_read(reg_addr(3, REG_EDGE));
        // wrong base and out-of-range banks
        add_read(32'h1234_5008);
        add_read(reg_addr(4, REG_OUT));
        add_read(reg_addr(15, REG_DIR));
        add_write(reg_addr(0, REG_OUT) ^ 32'h0000_1000, 32'hffff_ffff, 4'hf);
        add_write(reg_addr(4, REG_OUT), 32'hdead_beef, 4'hf);
        add_write(reg_addr(5, REG_DIR), 32'hcafe_f00d, 4'hf);
        add_read(reg_addr(0, REG_OUT));
        add_read(reg_addr(1, REG_DIR));
        add_idle();
    endtask

    task automatic check_word(string name, data_t exp, data_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s expected %08h got %08h", name, exp, got);
        end
    endtask

    task automatic run_row(int idx);
        row_t r;
        op_e  op;
        int   errs_before;
        int   b;
        r = rows[idx];
        op = r.op;
        errs_before = errors;
        case (op)
            OP_WRITE: begin
                dbus_req = '{addr: r.addr, wrdata: r.data, byteenable: r.be,
                             read: 1'b0, write: 1'b1};
                #2;
                check_word("dbus_stall_o", '0, data_t'(dbus_stall));
                @(negedge clk);
                dbus_req = '0;
                b = pin_bank(r.addr);
                check_word($sformatf("gpio_pins_o[%0d]", b), r.exp_data, gpio_pins_o[b]);
                check_word($sformatf("gpio_oe_o[%0d]", b), r.exp_oe, gpio_oe_o[b]);
            end
            OP_READ: begin
                dbus_req = '{addr: r.addr, wrdata: '0, byteenable: 4'hf,
                             read: 1'b1, write: 1'b0};
                #2;
                check_word("dbus_stall_o", 32'h1, data_t'(dbus_stall));
                @(negedge clk);
                check_word("dbus_stall_o", '0, data_t'(dbus_stall));
                check_word("dbus_rddata_o", r.exp_data, dbus_rddata);
                check_word("irq_o", data_t'(r.exp_irq), data_t'(irq));
                // the master drops the request after the cycle without stall
                @(negedge clk);
                dbus_req = '0;
            end
            OP_PINS: begin
                gpio_pins_i[r.addr[1:0]] = r.data;
                repeat (4) @(negedge clk);
                check_word("irq_o", data_t'(r.exp_irq), data_t'(irq));
            end
            default: begin
                @(negedge clk);
                check_word("irq_o", data_t'(r.exp_irq), data_t'(irq));
            end
        endcase
        $display("row %0d %s addr %08h data %08h %s", idx, op.name(), r.addr, r.data,
                 (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        reset_i = 1'b1;
        dbus_req = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            gpio_pins_i[b] = '0;
        end
        errors = 0;
        checks = 0;
        cycles = 0;
        cycle_limit = 0;
        seed = 32'hcf0f58b4;
        build_table();
        cycle_limit = rows.size() * 8 + 100;
        repeat (5) @(negedge clk);
        reset_i = 1'b0;
        #2;
        check_word("dbus_stall_o", '0, data_t'(dbus_stall));
        check_word("irq_o", '0, data_t'(irq));
        for (int b = 0; b < NUM_BANKS; b++) begin
            check_word($sformatf("gpio_pins_o[%0d]", b), '0, gpio_pins_o[b]);
            check_word($sformatf("gpio_oe_o[%0d]", b), '0, gpio_oe_o[b]);
        end
        @(negedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: hdl/gpio_subsys_top.sv
`timescale 1ns/1ps

module gpio_subsys_top
    import bus_pkg::*;
    import gpio_pkg::*;
#(
    parameter int unsigned NUM_BANKS = 4
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  bus_req_t             dbus_req_i,
    output data_t                dbus_rddata_o,
    output logic                 dbus_stall_o,
    input  pin_t                 gpio_pins_i [NUM_BANKS],
    output pin_t                 gpio_pins_o [NUM_BANKS],
    output pin_t                 gpio_oe_o [NUM_BANKS],
    output logic [NUM_BANKS-1:0] irq_o
);

    bank_req_t            bank_req [NUM_BANKS];
    data_t                bank_rddata [NUM_BANKS];
    logic [NUM_BANKS-1:0] bank_irq;
    logic                 rd_pending;
    bank_idx_t            rd_bank;
    logic                 rd_hit;

    dbus_decode #(
        .NUM_BANKS(NUM_BANKS)
    ) decode_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_i       (dbus_req_i),
        .stall_o     (dbus_stall_o),
        .bank_req_o  (bank_req),
        .rd_pending_o(rd_pending),
        .rd_bank_o   (rd_bank),
        .rd_hit_o    (rd_hit)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        gpio_bank bank_inst (
            .clk     (clk),
            .reset_i (reset_i),
            .req_i   (bank_req[i]),
            .rddata_o(bank_rddata[i]),
            .irq_o   (bank_irq[i]),
            .pins_i  (gpio_pins_i[i]),
            .pins_o  (gpio_pins_o[i]),
            .oe_o    (gpio_oe_o[i])
        );
    end

    dbus_return #(
        .NUM_BANKS(NUM_BANKS)
    ) return_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .rd_pending_i (rd_pending),
        .rd_bank_i    (rd_bank),
        .rd_hit_i     (rd_hit),
        .bank_rddata_i(bank_rddata),
        .bank_irq_i   (bank_irq),
        .rddata_o     (dbus_rddata_o),
        .irq_o        (irq_o)
    );

endmodule

// File: hdl/dbus_return.sv
`timescale 1ns/1ps

module dbus_return
    import bus_pkg::*;
    import gpio_pkg::*;
#(
    parameter int unsigned NUM_BANKS = 4
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 rd_pending_i,
    input  bank_idx_t            rd_bank_i,
    input  logic                 rd_hit_i,
    input  data_t                bank_rddata_i [NUM_BANKS],
    input  logic [NUM_BANKS-1:0] bank_irq_i,
    output data_t                rddata_o,
    output logic [NUM_BANKS-1:0] irq_o
);

    bank_idx_t bank_q;
    logic      hit_q;

    // remember which bank answers the read in flight
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bank_q <= '0;
            hit_q  <= 1'b0;
        end else if (rd_pending_i) begin
            bank_q <= rd_bank_i;
            hit_q  <= rd_hit_i;
        end
    end

    // bank data is registered at the same edge, so the mux is valid in DONE
    always_comb begin
        rddata_o = UNMAPPED_DATA;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (hit_q && (bank_q == i)) begin
                rddata_o = bank_rddata_i[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            irq_o <= '0;
        end else begin
            irq_o <= bank_irq_i;
        end
    end

    // decoder only flags a hit inside the bank range
    assert property (@(posedge clk) disable iff (reset_i) rd_hit_i |-> (rd_bank_i < NUM_BANKS))
        else $error("dbus_return: hit on bank %0d out of range", rd_bank_i);

endmodule

// File: hdl/gpio_bank.sv
`timescale 1ns/1ps

module gpio_bank
    import bus_pkg::*;
    import gpio_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  bank_req_t req_i,
    output data_t     rddata_o,
    output logic      irq_o,
    input  pin_t      pins_i,
    output pin_t      pins_o,
    output pin_t      oe_o
);

    pin_t  out_q;
    pin_t  dir_q;
    pin_t  meta_q;
    pin_t  in_q;
    pin_t  in_prev_q;
    pin_t  edge_q;
    pin_t  rise;
    pin_t  edge_clr;
    data_t lane_mask;
    logic  wr_out;
    logic  wr_dir;
    logic  wr_edge;

    // expand byte enables into a bit mask
    for (genvar b = 0; b < $bits(byte_en_t); b++) begin : g_lane
        assign lane_mask[8*b +: 8] = {8{req_i.byteenable[b]}};
    end

    assign wr_out  = req_i.wr && (req_i.reg_sel == REG_OUT);
    assign wr_dir  = req_i.wr && (req_i.reg_sel == REG_DIR);
    assign wr_edge = req_i.wr && (req_i.reg_sel == REG_EDGE);

    // write-one-to-clear on the edge register
    assign edge_clr = wr_edge ? (req_i.wrdata & lane_mask) : '0;

    // only pins configured as inputs can capture
    assign rise = in_q & ~in_prev_q & ~dir_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_q <= '0;
            dir_q <= '0;
        end else begin
            if (wr_out) begin
                out_q <= (out_q & ~lane_mask) | (req_i.wrdata & lane_mask);
            end
            if (wr_dir) begin
                dir_q <= (dir_q & ~lane_mask) | (req_i.wrdata & lane_mask);
            end
        end
    end

    // two-flop synchronizer, in_q is the IN register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            meta_q    <= '0;
            in_q      <= '0;
            in_prev_q <= '0;
        end else begin
            meta_q    <= pins_i;
            in_q      <= meta_q;
            in_prev_q <= in_q;
        end
    end

    // a new edge wins over a clear of the same bit
    always_ff @(posedge clk) begin
        if (reset_i) begin
            edge_q <= '0;
        end else begin
            edge_q <= (edge_q & ~edge_clr) | rise;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.rd) begin
            case (req_i.reg_sel)
                REG_OUT:  rddata_o <= out_q;
                REG_DIR:  rddata_o <= dir_q;
                REG_IN:   rddata_o <= in_q;
                REG_EDGE: rddata_o <= edge_q;
                default:  rddata_o <= UNMAPPED_DATA;
            endcase
        end
    end

    assign irq_o  = |edge_q;
    assign pins_o = out_q;
    assign oe_o   = dir_q;

    // decoder gives a bank one access per cycle
    assert property (@(posedge clk) disable iff (reset_i) !(req_i.rd && req_i.wr))
        else $error("gpio_bank: rd and wr in the same cycle");

endmodule

// File: hdl/dbus_decode.sv
`timescale 1ns/1ps

module dbus_decode
    import bus_pkg::*;
    import gpio_pkg::*;
#(
    parameter int unsigned NUM_BANKS = 4
) (
    input  logic      clk,
    input  logic      reset_i,
    input  bus_req_t  req_i,
    output logic      stall_o,
    output bank_req_t bank_req_o [NUM_BANKS],
    output logic      rd_pending_o,
    output bank_idx_t rd_bank_o,
    output logic      rd_hit_o
);

    typedef enum logic {
        IDLE,
        DONE
    } state_e;

    state_e               state_q;
    state_e               state_d;
    bank_idx_t            bank_sel;
    logic                 base_match;
    logic                 hit;
    logic                 issue_rd;
    logic                 issue_wr;
    logic [NUM_BANKS-1:0] rd_vec;
    logic [NUM_BANKS-1:0] wr_vec;

    // the bank field is 8 bits wide but the subsystem supports at most 16 banks
    if (NUM_BANKS < 1 || NUM_BANKS > 16) begin : g_range_check
        $error("dbus_decode: NUM_BANKS must be 1 to 16");
    end

    assign bank_sel   = req_i.addr[11:4];
    assign base_match = (req_i.addr[31:12] == GPIO_BASE);
    assign hit        = base_match && (bank_sel < NUM_BANKS);

    // a read is issued once from IDLE and its data is valid in DONE
    assign issue_rd = (state_q == IDLE) && req_i.read;
    assign issue_wr = (state_q == IDLE) && req_i.write;

    assign stall_o      = issue_rd;
    assign rd_pending_o = issue_rd;
    assign rd_bank_o    = bank_sel;
    assign rd_hit_o     = hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i.read) begin
                    state_d = DONE;
                end
            end
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_strobe
        assign rd_vec[i] = issue_rd && hit && (bank_sel == i);
        assign wr_vec[i] = issue_wr && hit && (bank_sel == i);
        assign bank_req_o[i] = '{reg_sel:    gpio_reg_e'(req_i.addr[3:2]),
                                 wrdata:     req_i.wrdata,
                                 byteenable: req_i.byteenable,
                                 rd:         rd_vec[i],
                                 wr:         wr_vec[i]};
    end

    // CPU side never drives both strobes
    assert property (@(posedge clk) disable iff (reset_i) !(req_i.read && req_i.write))
        else $error("dbus_decode: read and write high together");

    assert property (@(posedge clk) disable iff (reset_i) $onehot0({rd_vec, wr_vec}))
        else $error("dbus_decode: more than one bank strobe");

endmodule

// File: hdl/gpio_pkg.sv
package gpio_pkg;

    import bus_pkg::*;

    // a bank is always exactly one data word wide, since writes go per byte lane
    typedef logic [$bits(data_t)-1:0] pin_t;

    // bank index field, address bits 11:4
    typedef logic [7:0] bank_idx_t;

    // register select by word offset, address bits 3:2
    typedef enum logic [1:0] {
        REG_OUT  = 2'd0,
        REG_DIR  = 2'd1,
        REG_IN   = 2'd2,
        REG_EDGE = 2'd3
    } gpio_reg_e;

    // decoded request for one bank, rd and wr are single-cycle pulses
    typedef struct packed {
        gpio_reg_e reg_sel;
        data_t     wrdata;
        byte_en_t  byteenable;
        logic      rd;
        logic      wr;
    } bank_req_t;

endpackage

// File: hdl/bus_pkg.sv
package bus_pkg;

    // byte address on the CPU data bus
    typedef logic [31:0] addr_t;

    // read or write data word
    typedef logic [31:0] data_t;

    // one enable per byte lane, lane 0 is bits 7:0
    typedef logic [3:0] byte_en_t;

    // master request, held stable by the CPU while stall is high
    typedef struct packed {
        addr_t    addr;
        data_t    wrdata;
        byte_en_t byteenable;
        logic     read;
        logic     write;
    } bus_req_t;

    // address bits 31:12 of the GPIO window
    localparam logic [19:0] GPIO_BASE = 20'hbfd01;

    // returned for reads that hit no bank
    localparam data_t UNMAPPED_DATA = '0;

endpackage
